// ==== cache_cases.txt ====
// columns: op addr strb wdata exp_rdata exp_event, all hex
// op 0 read, 1 write, 2 invalidate; for writes exp_rdata is the back-end word afterwards
// exp_event: 8 rd_hit, 4 rd_miss, 2 wr_hit, 1 wr_miss, 0 none
0 0010 0 00000000 ffef0010 4
0 0010 0 00000000 ffef0010 8
0 0123 0 00000000 fedc0123 4
1 0123 3 aabbccdd fedcccdd 2
0 0123 0 00000000 fedcccdd 8
1 0456 f 12345678 12345678 1
0 0456 0 00000000 12345678 4
0 0456 0 00000000 12345678 8
1 0124 8 99000000 99db0124 1
0 0124 0 00000000 99db0124 4
// three addresses in set 5
0 0005 0 00000000 fffa0005 4
0 000d 0 00000000 fff2000d 4
0 0015 0 00000000 ffea0015 4
0 000d 0 00000000 fff2000d 8
0 0005 0 00000000 fffa0005 4
0 0015 0 00000000 ffea0015 8
0 000d 0 00000000 fff2000d 4
// invalidate and refill
0 0010 0 00000000 ffef0010 8
2 0000 0 00000000 00000000 0
0 0010 0 00000000 ffef0010 4
0 0010 0 00000000 ffef0010 8
0 0123 0 00000000 fedcccdd 4
1 0010 1 000000a5 ffef00a5 2
0 0010 0 00000000 ffef00a5 8
0 fff8 0 00000000 0007fff8 4
0 0010 0 00000000 ffef00a5 8

// ==== verilog.f ====
+incdir+.
cache_bus_pkg.sv
cache_store_pkg.sv
cache_mem_array.sv
cache_tag_lookup.sv
cache_data_path.sv
cache_ctrl.sv
cache_top.sv
tb_backend_mem.sv
tb_cache.sv

// ==== tb_cache.sv ====
`default_nettype none
`include "cache_consts.svh"

module tb_cache
   import cache_bus_pkg::*;
   import cache_store_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NCASES             = 26;
   localparam int TIMEOUT            = 50;
   localparam logic [3:0] EV_RD_HIT  = 4'h8;

   logic                     clk;
   logic                     rst;
   logic                     invalidate;
   fe_req_t                  fe_req;
   fe_resp_t                 fe_resp;
   be_req_t                  be_req;
   be_resp_t                 be_resp;
   monitor_t                 mon;
   logic [`CACHE_ADDR_W-1:0] peek_addr;
   logic [`CACHE_DATA_W-1:0] peek_data;
   logic [31:0]              case_words [6*NCASES];
   int                       errors;
   int                       timeouts;
   int unsigned              seed;

   cache_top uut (
      .clk_i        (clk),
      .rst_i        (rst),
      .invalidate_i (invalidate),
      .fe_req_i     (fe_req),
      .be_resp_i    (be_resp),
      .fe_resp_o    (fe_resp),
      .be_req_o     (be_req),
      .mon_o        (mon)
   );

   tb_backend_mem u_backend (
      .clk_i       (clk),
      .rst_i       (rst),
      .be_req_i    (be_req),
      .be_resp_o   (be_resp),
      .peek_addr_i (peek_addr),
      .peek_data_o (peek_data)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic wait_ready(input string what);
      int cnt;
      cnt = 0;
      while (!fe_resp.ready && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!fe_resp.ready) begin
         $display("timeout after %0d cycles waiting for front-end ready on %s", TIMEOUT, what);
         timeouts++;
      end
   endtask

   task automatic wait_rvalid();
      int cnt;
      cnt = 0;
      while (!fe_resp.rvalid && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!fe_resp.rvalid) begin
         $display("timeout after %0d cycles waiting for front-end rvalid", TIMEOUT);
         timeouts++;
      end
   endtask

   task automatic run_access(input logic [`CACHE_ADDR_W-1:0] addr,
                             input logic [`CACHE_NBYTES-1:0] strb,
                             input logic [`CACHE_DATA_W-1:0] wdata,
                             input logic [`CACHE_DATA_W-1:0] exp_data,
                             input logic [3:0]               exp_ev);
      @(posedge clk);
      #1;
      fe_req.avalid = 1'b1;
      fe_req.addr   = addr;
      fe_req.wstrb  = strb;
      fe_req.wdata  = wdata;
      @(negedge clk);
      wait_ready("request acceptance");
      @(posedge clk);
      #1;
      fe_req.avalid = 1'b0;
      // lookup cycle one after acceptance
      @(negedge clk);
      check_value("mon_o", 32'(exp_ev), 32'(mon));
      check_value("fe_resp_o.ready", 32'd0, 32'(fe_resp.ready));
      if (strb != '0) begin
         wait_ready("write-through completion");
         peek_addr = addr;
         #1;
         check_value("backend word", exp_data, peek_data);
      end else begin
         if (exp_ev == EV_RD_HIT) begin
            check_value("fe_resp_o.rvalid", 32'd1, 32'(fe_resp.rvalid));
         end else begin
            check_value("fe_resp_o.rvalid", 32'd0, 32'(fe_resp.rvalid));
            wait_rvalid();
         end
         if (fe_resp.rvalid) begin
            check_value("fe_resp_o.rdata", exp_data, fe_resp.rdata);
         end
      end
   endtask

   task automatic pulse_invalidate();
      @(posedge clk);
      #1;
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
   endtask

   initial begin
      int base;
      seed = 32'hc1e9_594a;
      void'($urandom(seed));
      clk        = 1'b0;
      rst        = 1'b1;
      invalidate = 1'b0;
      fe_req     = '0;
      peek_addr  = '0;
      errors     = 0;
      timeouts   = 0;
      $readmemh("cache_cases.txt", case_words);
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // idle outputs after reset
      @(negedge clk);
      check_value("fe_resp_o.ready", 32'd1, 32'(fe_resp.ready));
      check_value("fe_resp_o.rvalid", 32'd0, 32'(fe_resp.rvalid));
      check_value("be_req_o.avalid", 32'd0, 32'(be_req.avalid));
      check_value("mon_o", 32'd0, 32'(mon));
      for (int i = 0; i < NCASES; i++) begin
         base = 6 * i;
         if (case_words[base] == 32'h2) begin
            pulse_invalidate();
         end else begin
            run_access(case_words[base + 1][`CACHE_ADDR_W-1:0],
                       case_words[base + 2][`CACHE_NBYTES-1:0],
                       case_words[base + 3],
                       case_words[base + 4],
                       case_words[base + 5][3:0]);
         end
      end
      repeat (2) @(posedge clk);
      $display("failed checks: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_backend_mem.sv ====
`default_nettype none
`include "cache_consts.svh"

module tb_backend_mem
   import cache_bus_pkg::*;
(
   input  wire logic                     clk_i,
   input  wire logic                     rst_i,
   input  wire be_req_t                  be_req_i,
   output be_resp_t                      be_resp_o,
   input  wire logic [`CACHE_ADDR_W-1:0] peek_addr_i,
   output logic [`CACHE_DATA_W-1:0]      peek_data_o
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [`CACHE_DATA_W-1:0] mem_q [2**`CACHE_ADDR_W];
   logic [1:0]               ready_cnt_q;
   logic [1:0]               rd_cnt_q;
   logic                     busy_q;
   logic [`CACHE_ADDR_W-1:0] rd_addr_q;
   logic                     accept;

   // word at address a holds ~a above a
   initial begin
      for (int a = 0; a < 2**`CACHE_ADDR_W; a++) begin
         mem_q[a] = {~16'(a), 16'(a)};
      end
   end

   assign accept           = be_req_i.avalid && be_resp_o.ready;
   assign be_resp_o.ready  = !busy_q && (ready_cnt_q == 2'd0);
   assign be_resp_o.rvalid = busy_q && (rd_cnt_q == 2'd0);
   assign be_resp_o.rdata  = mem_q[rd_addr_q];
   assign peek_data_o      = mem_q[peek_addr_i];

   always @(posedge clk_i) begin
      if (rst_i) begin
         busy_q      <= 1'b0;
         ready_cnt_q <= 2'd0;
         rd_cnt_q    <= 2'd0;
         rd_addr_q   <= '0;
      end else if (accept) begin
         // fresh ready delay for the next request
         ready_cnt_q <= 2'($urandom);
         if (be_req_i.wstrb == '0) begin
            busy_q    <= 1'b1;
            rd_cnt_q  <= 2'($urandom);
            rd_addr_q <= be_req_i.addr;
         end
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (be_req_i.wstrb[b]) begin
               mem_q[be_req_i.addr][8*b +: 8] <= be_req_i.wdata[8*b +: 8];
            end
         end
      end else if (busy_q) begin
         // read latency countdown with rvalid at zero
         if (rd_cnt_q == 2'd0) begin
            busy_q <= 1'b0;
         end else begin
            rd_cnt_q <= rd_cnt_q - 2'd1;
         end
      end else if (be_req_i.avalid && (ready_cnt_q != 2'd0)) begin
         ready_cnt_q <= ready_cnt_q - 2'd1;
      end
   end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`default_nettype none
`include "cache_consts.svh"

module cache_top
   import cache_bus_pkg::*;
   import cache_store_pkg::*;
(
   input  wire logic     clk_i,
   input  wire logic     rst_i,
   input  wire logic     invalidate_i,
   input  wire fe_req_t  fe_req_i,
   input  wire be_resp_t be_resp_i,
   output fe_resp_t      fe_resp_o,
   output be_req_t       be_req_o,
   output monitor_t      mon_o
);

   lookup_t                                      lookup;
   logic [`CACHE_NWAYS-1:0][`CACHE_DATA_W-1:0]   way_data;
   logic                                         look;
   logic [`CACHE_NSETS_W-1:0]                    look_idx;
   logic [`CACHE_NSETS_W-1:0]                    idx;
   tag_entry_t                                   tag;
   logic                                         wr;
   logic                                         wr_way;
   logic [`CACHE_NBYTES-1:0]                     wr_strb;
   logic [`CACHE_DATA_W-1:0]                     wr_data;
   logic                                         fill;
   logic                                         fill_way;
   logic [`CACHE_DATA_W-1:0]                     fill_data;

   cache_tag_lookup u_tag_lookup (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .invalidate_i (invalidate_i),
      .look_i       (look),
      .look_idx_i   (look_idx),
      .fill_i       (fill),
      .fill_way_i   (fill_way),
      .fill_idx_i   (idx),
      .fill_tag_i   (tag),
      .cmp_tag_i    (tag),
      .result_o     (lookup)
   );

   cache_data_path u_data_path (
      .clk_i        (clk_i),
      .rd_i         (look),
      .rd_idx_i     (look_idx),
      .wr_i         (wr),
      .wr_way_i     (wr_way),
      .wr_idx_i     (idx),
      .wr_strb_i    (wr_strb),
      .wr_data_i    (wr_data),
      .fill_i       (fill),
      .fill_way_i   (fill_way),
      .fill_data_i  (fill_data),
      .way_data_o   (way_data)
   );

   cache_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe_req_i     (fe_req_i),
      .be_resp_i    (be_resp_i),
      .lookup_i     (lookup),
      .way_data_i   (way_data),
      .fe_resp_o    (fe_resp_o),
      .be_req_o     (be_req_o),
      .mon_o        (mon_o),
      .look_o       (look),
      .look_idx_o   (look_idx),
      .idx_o        (idx),
      .tag_o        (tag),
      .wr_o         (wr),
      .wr_way_o     (wr_way),
      .wr_strb_o    (wr_strb),
      .wr_data_o    (wr_data),
      .fill_o       (fill),
      .fill_way_o   (fill_way),
      .fill_data_o  (fill_data)
   );

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
`default_nettype none
`include "cache_consts.svh"

module cache_ctrl
   import cache_bus_pkg::*;
   import cache_store_pkg::*;
(
   input  wire logic                                    clk_i,
   input  wire logic                                    rst_i,
   input  wire fe_req_t                                 fe_req_i,
   input  wire be_resp_t                                be_resp_i,
   input  wire lookup_t                                 lookup_i,
   input  wire logic [`CACHE_NWAYS-1:0][`CACHE_DATA_W-1:0] way_data_i,
   output fe_resp_t                                     fe_resp_o,
   output be_req_t                                      be_req_o,
   output monitor_t                                     mon_o,
   output logic                                         look_o,
   output logic [`CACHE_NSETS_W-1:0]                    look_idx_o,
   output logic [`CACHE_NSETS_W-1:0]                    idx_o,
   output tag_entry_t                                   tag_o,
   output logic                                         wr_o,
   output logic                                         wr_way_o,
   output logic [`CACHE_NBYTES-1:0]                     wr_strb_o,
   output logic [`CACHE_DATA_W-1:0]                     wr_data_o,
   output logic                                         fill_o,
   output logic                                         fill_way_o,
   output logic [`CACHE_DATA_W-1:0]                     fill_data_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_REFILL_REQ,
      ST_REFILL_WAIT,
      ST_RESPOND,
      ST_WRITE_THRU
   } state_t;

   state_t                    state_q;
   state_t                    state_d;
   fe_req_t                   req_q;
   logic                      victim_q;
   logic [`CACHE_DATA_W-1:0]  refill_q;
   logic                      accept;
   logic                      is_write;
   logic                      in_lookup;
   logic                      be_active;

   assign accept    = fe_req_i.avalid && (state_q == ST_IDLE);
   assign is_write  = |req_q.wstrb;
   assign in_lookup = (state_q == ST_LOOKUP);

   // request, victim and refilled word
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
      if (in_lookup) begin
         victim_q <= lookup_i.victim_way;
      end
      if (fill_o) begin
         refill_q <= be_resp_i.rdata;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               state_d = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (is_write) begin
               state_d = be_resp_i.ready ? ST_IDLE : ST_WRITE_THRU;
            end else if (!lookup_i.hit) begin
               state_d = be_resp_i.ready ? ST_REFILL_WAIT : ST_REFILL_REQ;
            end else begin
               state_d = ST_IDLE;
            end
         end
         ST_REFILL_REQ: begin
            if (be_resp_i.ready) begin
               state_d = ST_REFILL_WAIT;
            end
         end
         ST_REFILL_WAIT: begin
            if (be_resp_i.rvalid) begin
               state_d = ST_RESPOND;
            end
         end
         ST_RESPOND: begin
            state_d = ST_IDLE;
         end
         ST_WRITE_THRU: begin
            if (be_resp_i.ready) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // event classification
   assign mon_o.rd_hit  = in_lookup && !is_write && lookup_i.hit;
   assign mon_o.rd_miss = in_lookup && !is_write && !lookup_i.hit;
   assign mon_o.wr_hit  = in_lookup && is_write && lookup_i.hit;
   assign mon_o.wr_miss = in_lookup && is_write && !lookup_i.hit;

   // back end starts in the lookup cycle on a miss or any write
   assign be_active = (in_lookup && (is_write || !lookup_i.hit))
                      || (state_q == ST_REFILL_REQ) || (state_q == ST_WRITE_THRU);

   assign be_req_o.avalid = be_active;
   assign be_req_o.addr   = req_q.addr;
   assign be_req_o.wstrb  = req_q.wstrb;
   assign be_req_o.wdata  = req_q.wdata;

   // front-end response
   assign fe_resp_o.ready  = (state_q == ST_IDLE);
   assign fe_resp_o.rvalid = mon_o.rd_hit || (state_q == ST_RESPOND);
   assign fe_resp_o.rdata  = (state_q == ST_RESPOND) ? refill_q
                                                      : way_data_i[lookup_i.hit_way];

   // array commands
   assign look_o      = accept;
   assign look_idx_o  = fe_req_i.addr[`CACHE_NSETS_W-1:0];
   assign idx_o       = req_q.addr[`CACHE_NSETS_W-1:0];
   assign tag_o.tag   = req_q.addr[`CACHE_ADDR_W-1:`CACHE_NSETS_W];
   assign wr_o        = mon_o.wr_hit;
   assign wr_way_o    = lookup_i.hit_way;
   assign wr_strb_o   = req_q.wstrb;
   assign wr_data_o   = req_q.wdata;
   assign fill_o      = (state_q == ST_REFILL_WAIT) && be_resp_i.rvalid;
   assign fill_way_o  = victim_q;
   assign fill_data_o = be_resp_i.rdata;

endmodule

`default_nettype wire

// ==== cache_data_path.sv ====
`default_nettype none
`include "cache_consts.svh"

module cache_data_path (
   input  wire logic                                    clk_i,
   input  wire logic                                    rd_i,
   input  wire logic [`CACHE_NSETS_W-1:0]               rd_idx_i,
   input  wire logic                                    wr_i,
   input  wire logic                                    wr_way_i,
   input  wire logic [`CACHE_NSETS_W-1:0]               wr_idx_i,
   input  wire logic [`CACHE_NBYTES-1:0]                wr_strb_i,
   input  wire logic [`CACHE_DATA_W-1:0]                wr_data_i,
   input  wire logic                                    fill_i,
   input  wire logic                                    fill_way_i,
   input  wire logic [`CACHE_DATA_W-1:0]                fill_data_i,
   output logic [`CACHE_NWAYS-1:0][`CACHE_DATA_W-1:0]   way_data_o
);

   typedef logic [`CACHE_DATA_W-1:0] word_t;

   word_t merged;
   word_t wr_word;

   // merge strobed bytes into the word read during lookup
   always_comb begin
      merged = way_data_o[wr_way_i];
      for (int b = 0; b < `CACHE_NBYTES; b++) begin
         if (wr_strb_i[b]) begin
            merged[8*b +: 8] = wr_data_i[8*b +: 8];
         end
      end
   end

   // refill replaces the whole word
   assign wr_word = fill_i ? fill_data_i : merged;

   for (genvar w = 0; w < `CACHE_NWAYS; w++) begin : g_way
      cache_mem_array #(
         .payload_t (word_t),
         .DEPTH_W   (`CACHE_NSETS_W)
      ) u_data_mem (
         .clk_i     (clk_i),
         .rd_en_i   (rd_i),
         .rd_addr_i (rd_idx_i),
         .wr_en_i   ((fill_i && (fill_way_i == 1'(w))) || (wr_i && (wr_way_i == 1'(w)))),
         .wr_addr_i (wr_idx_i),
         .wr_data_i (wr_word),
         .rd_data_o (way_data_o[w])
      );
   end

endmodule

`default_nettype wire

// ==== cache_tag_lookup.sv ====
`default_nettype none
`include "cache_consts.svh"

module cache_tag_lookup
   import cache_store_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      rst_i,
   input  wire logic                      invalidate_i,
   input  wire logic                      look_i,
   input  wire logic [`CACHE_NSETS_W-1:0] look_idx_i,
   input  wire logic                      fill_i,
   input  wire logic                      fill_way_i,
   input  wire logic [`CACHE_NSETS_W-1:0] fill_idx_i,
   input  wire tag_entry_t                fill_tag_i,
   input  wire tag_entry_t                cmp_tag_i,
   output lookup_t                        result_o
);

   localparam int NSETS = 2 ** `CACHE_NSETS_W;

   tag_entry_t                          way_tag [`CACHE_NWAYS];
   logic [`CACHE_NWAYS-1:0]             way_hit;
   logic [`CACHE_NWAYS-1:0][NSETS-1:0]  valid_q;
   logic [NSETS-1:0]                    ptr_q;
   logic [`CACHE_NWAYS-1:0]             valid_rd_q;
   logic                                ptr_rd_q;

   for (genvar w = 0; w < `CACHE_NWAYS; w++) begin : g_way
      cache_mem_array #(
         .payload_t (tag_entry_t),
         .DEPTH_W   (`CACHE_NSETS_W)
      ) u_tag_mem (
         .clk_i     (clk_i),
         .rd_en_i   (look_i),
         .rd_addr_i (look_idx_i),
         .wr_en_i   (fill_i && (fill_way_i == 1'(w))),
         .wr_addr_i (fill_idx_i),
         .wr_data_i (fill_tag_i),
         .rd_data_o (way_tag[w])
      );

      assign way_hit[w] = valid_rd_q[w] && (way_tag[w] == cmp_tag_i);
   end

   // valid bits and round-robin pointers
   // invalidate beats a fill on the same edge
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= '0;
         ptr_q   <= '0;
      end else begin
         if (invalidate_i) begin
            valid_q <= '0;
         end else if (fill_i) begin
            valid_q[fill_way_i][fill_idx_i] <= 1'b1;
         end
         if (fill_i) begin
            ptr_q[fill_idx_i] <= ~ptr_q[fill_idx_i];
         end
      end
   end

   // read alongside the tag arrays
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_rd_q <= '0;
         ptr_rd_q   <= 1'b0;
      end else if (look_i) begin
         for (int w = 0; w < `CACHE_NWAYS; w++) begin
            valid_rd_q[w] <= valid_q[w][look_idx_i];
         end
         ptr_rd_q <= ptr_q[look_idx_i];
      end
   end

   // at most one way hits
   assign result_o.hit        = |way_hit;
   assign result_o.hit_way    = way_hit[1];
   assign result_o.victim_way = ptr_rd_q;

endmodule

`default_nettype wire

// ==== cache_mem_array.sv ====
`default_nettype none
`include "cache_consts.svh"

module cache_mem_array #(
   parameter type payload_t = logic [`CACHE_DATA_W-1:0],
   parameter int  DEPTH_W   = `CACHE_NSETS_W
) (
   input  wire logic               clk_i,
   input  wire logic               rd_en_i,
   input  wire logic [DEPTH_W-1:0] rd_addr_i,
   input  wire logic               wr_en_i,
   input  wire logic [DEPTH_W-1:0] wr_addr_i,
   input  wire payload_t           wr_data_i,
   output payload_t                rd_data_o
);

   localparam int DEPTH = 2 ** DEPTH_W;

   payload_t mem_q [DEPTH];

   // write at the edge
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem_q[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read port that holds when not enabled
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_o <= mem_q[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== cache_store_pkg.sv ====
`default_nettype none
`include "cache_consts.svh"

package cache_store_pkg;

   typedef struct packed {
      logic [`CACHE_TAG_W-1:0] tag;
   } tag_entry_t;

   // tag lookup result for the cycle after the read
   typedef struct packed {
      logic hit;
      logic hit_way;
      logic victim_way;
   } lookup_t;

   // one-cycle event pulses
   typedef struct packed {
      logic rd_hit;
      logic rd_miss;
      logic wr_hit;
      logic wr_miss;
   } monitor_t;

endpackage

`default_nettype wire

// ==== cache_bus_pkg.sv ====
`default_nettype none
`include "cache_consts.svh"

package cache_bus_pkg;

   // front-end request with zero wstrb for a read
   typedef struct packed {
      logic                      avalid;
      logic [`CACHE_ADDR_W-1:0]  addr;
      logic [`CACHE_NBYTES-1:0]  wstrb;
      logic [`CACHE_DATA_W-1:0]  wdata;
   } fe_req_t;

   typedef struct packed {
      logic                      ready;
      logic                      rvalid;
      logic [`CACHE_DATA_W-1:0]  rdata;
   } fe_resp_t;

   // back end uses the same signal set
   typedef struct packed {
      logic                      avalid;
      logic [`CACHE_ADDR_W-1:0]  addr;
      logic [`CACHE_NBYTES-1:0]  wstrb;
      logic [`CACHE_DATA_W-1:0]  wdata;
   } be_req_t;

   typedef struct packed {
      logic                      ready;
      logic                      rvalid;
      logic [`CACHE_DATA_W-1:0]  rdata;
   } be_resp_t;

endpackage

`default_nettype wire

// ==== cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// front-end word address width
`define CACHE_ADDR_W   16
`define CACHE_DATA_W   32
`define CACHE_NBYTES   4

// set index bits for one-word lines
`define CACHE_NSETS_W  3
`define CACHE_NWAYS    2

// upper address bits above the index
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_NSETS_W)

`endif
